// File: bench/mem_model.sv
// ====================
// Behavioral line memory, all lines zero at start, in-order responses after 2 to 6 cycles
// While armed, the first checked response gets one byte inverted
// ====================
`timescale 1ns/1ps

module mem_model
(
    input  logic clk,
    input  logic reset,

    // Requests from the DUT
    input  logic rd_valid,
    input  logic [mem_test_pkg::ADDR_W-1:0] rd_addr,
    input  logic rd_meta,
    input  logic wr_valid,
    input  logic [mem_test_pkg::ADDR_W-1:0] wr_addr,
    input  logic [mem_test_pkg::DATA_W-1:0] wr_data,

    // Latency for a read sampled at this edge
    input  logic [2:0] latency,
    input  logic corrupt_arm,
    input  logic [2:0] corrupt_byte,

    output logic rsp_valid,
    output logic [mem_test_pkg::DATA_W-1:0] rsp_data,
    output logic rsp_meta,
    output logic corrupted
);

    logic [mem_test_pkg::DATA_W-1:0] lines [2**mem_test_pkg::ADDR_W];

    // Pending responses, oldest first
    logic [mem_test_pkg::DATA_W-1:0] pend_data [$];
    logic pend_meta [$];
    int pend_due [$];

    int cycle;
    int last_due;
    int due;
    logic arm;
    logic [2:0] byte_sel;
    logic [mem_test_pkg::DATA_W-1:0] line;
    logic meta;

    initial
    begin
        rsp_valid = 1'b0;
        rsp_data = '0;
        rsp_meta = 1'b0;
        corrupted = 1'b0;
        cycle = 0;
        last_due = 0;
        // Matches the cleared tag RAM
        foreach (lines[i])
        begin
            lines[i] = '0;
        end

        forever
        begin
            @(posedge clk);
            // Controls as they stood at the edge
            arm = corrupt_arm;
            byte_sel = corrupt_byte;
            cycle = cycle + 1;

            if (reset)
            begin
                pend_data.delete();
                pend_meta.delete();
                pend_due.delete();
                last_due = cycle;
            end
            else
            begin
                // Read first, a same-edge write is not seen
                if (rd_valid)
                begin
                    due = cycle + int'(latency);
                    // Keep issue order, one response per cycle
                    if (due <= last_due)
                    begin
                        due = last_due + 1;
                    end
                    last_due = due;
                    pend_data.push_back(lines[rd_addr]);
                    pend_meta.push_back(rd_meta);
                    pend_due.push_back(due);
                end
                if (wr_valid)
                begin
                    lines[wr_addr] = wr_data;
                end
            end

            #1;
            rsp_valid = 1'b0;
            if (!arm)
            begin
                corrupted = 1'b0;
            end
            if ((pend_due.size() > 0) && (pend_due[0] <= cycle))
            begin
                void'(pend_due.pop_front());
                line = pend_data.pop_front();
                meta = pend_meta.pop_front();
                // Once per arm, checked lines only
                if (arm && !corrupted && meta)
                begin
                    line[8*byte_sel +: 8] = line[8*byte_sel +: 8] ^ 8'hff;
                    corrupted = 1'b1;
                end
                rsp_valid = 1'b1;
                rsp_data = line;
                rsp_meta = meta;
            end
        end
    end

endmodule

// File: bench/mem_test_tb.sv
// ====================
// Testbench for the memory traffic tester with a behavioral memory beside the DUT
// Only the last run sets allow_conflicts, so its reads meet lines written before
// ====================
`timescale 1ns/1ps

module mem_test_tb;

    localparam int CLK_PERIOD = 8;
    localparam logic [31:0] SEED = 32'h7e38ee1a;
    localparam int RUN_LEN = 400;
    localparam int STALL_RUN_LEN = 300;
    // Five plain runs and one stalled run
    localparam int RUN_TOTAL = 5 * RUN_LEN + STALL_RUN_LEN;
    localparam int RAM_CLEAR = 2**mem_test_pkg::CHK_W;
    localparam int MARGIN = 500;

    logic clk = 1'b0;
    logic reset;
    logic start;
    logic [mem_test_pkg::COUNT_W-1:0] run_cycles;
    logic enable_reads;
    logic enable_writes;
    logic enable_checker;
    logic allow_conflicts;
    logic mem_stall;
    logic rsp_valid;
    logic [mem_test_pkg::DATA_W-1:0] rsp_data;
    logic rsp_meta;
    logic rd_valid;
    logic [mem_test_pkg::ADDR_W-1:0] rd_addr;
    logic rd_meta;
    logic wr_valid;
    logic [mem_test_pkg::ADDR_W-1:0] wr_addr;
    logic [mem_test_pkg::DATA_W-1:0] wr_data;
    logic busy;
    logic done;
    logic error;
    logic [mem_test_pkg::COUNT_W-1:0] cnt_rd_rsp;
    logic [mem_test_pkg::COUNT_W-1:0] cnt_wr;
    logic [mem_test_pkg::COUNT_W-1:0] cnt_checked;

    // Memory model controls
    logic [2:0] latency;
    logic corrupt_arm;
    logic [2:0] corrupt_byte;
    logic corrupted;

    // Stall pattern
    logic stall_mode;
    logic stall_level;
    int stall_left;
    logic stall_q = 1'b0;

    // Traffic seen at the ports since the last start
    int rd_seen;
    int wr_seen;
    int rsp_seen;
    int meta_seen;
    int tag_seen;
    int done_seen;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mem_test_top i_mem_test_top
    (
        .clk,
        .reset,
        .start,
        .run_cycles,
        .enable_reads,
        .enable_writes,
        .enable_checker,
        .allow_conflicts,
        .mem_stall,
        .rsp_valid,
        .rsp_data,
        .rsp_meta,
        .rd_valid,
        .rd_addr,
        .rd_meta,
        .wr_valid,
        .wr_addr,
        .wr_data,
        .busy,
        .done,
        .error,
        .cnt_rd_rsp,
        .cnt_wr,
        .cnt_checked
    );

    mem_model i_mem_model
    (
        .clk,
        .reset,
        .rd_valid,
        .rd_addr,
        .rd_meta,
        .wr_valid,
        .wr_addr,
        .wr_data,
        .latency,
        .corrupt_arm,
        .corrupt_byte,
        .rsp_valid,
        .rsp_data,
        .rsp_meta,
        .corrupted
    );

    task automatic report_error(input string msg);
        $display("FAIL %0t ns: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    // ====================
    // Random latency and stall stretches
    // ====================
    initial
    begin
        void'($urandom(SEED));
        latency = 3'd2;
        mem_stall = 1'b0;
        stall_level = 1'b0;
        stall_left = 0;
        forever
        begin
            @(posedge clk);
            #1;
            latency = 3'($urandom_range(6, 2));
            if (stall_left == 0)
            begin
                stall_level = 1'($urandom_range(1, 0));
                stall_left = $urandom_range(8, 1);
            end
            stall_left = stall_left - 1;
            mem_stall = stall_mode && stall_level;
        end
    end

    // ====================
    // Port monitor
    // ====================
    always @(posedge clk)
    begin
        if (reset || start)
        begin
            rd_seen = 0;
            wr_seen = 0;
            rsp_seen = 0;
            meta_seen = 0;
            tag_seen = 0;
            done_seen = 0;
        end
        else
        begin
            rd_seen = rd_seen + int'(rd_valid);
            wr_seen = wr_seen + int'(wr_valid);
            rsp_seen = rsp_seen + int'(rsp_valid);
            meta_seen = meta_seen + int'(rsp_valid && rsp_meta);
            // Checked lines that carry written data
            tag_seen = tag_seen + int'(rsp_valid && rsp_meta
                && (mem_test_pkg::line_to_tag(rsp_data) != '0));
            done_seen = done_seen + int'(done);
        end

        if (!reset)
        begin
            // Back-pressure holds off the next request
            assert (!(stall_q && (rd_valid || wr_valid)))
            else report_error("request issued after an edge with mem_stall high");
            // Bit 2 separates read lines from write lines
            assert (allow_conflicts || !rd_valid || (rd_addr[2] == 1'b0))
            else report_error($sformatf("read address %h has bit 2 set", rd_addr));
            assert (allow_conflicts || !wr_valid || (wr_addr[2] == 1'b1))
            else report_error($sformatf("write address %h has bit 2 clear", wr_addr));
        end
        stall_q = mem_stall;
    end

    // One run from start to the drained counters
    task automatic run_test
    (
        input logic [mem_test_pkg::COUNT_W-1:0] cycles,
        input logic checker_on,
        input logic stall_on,
        input logic conflicts_on,
        input logic corrupt_on,
        input logic [2:0] byte_sel,
        input logic expect_error
    );
        @(posedge clk);
        #1;
        run_cycles = cycles;
        enable_reads = 1'b1;
        enable_writes = 1'b1;
        enable_checker = checker_on;
        allow_conflicts = conflicts_on;
        stall_mode = stall_on;
        corrupt_arm = corrupt_on;
        corrupt_byte = byte_sel;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;

        while (!done)
        begin
            @(posedge clk);
            #1;
        end
        stall_mode = 1'b0;

        // Every issued read gets its response
        while (rsp_seen != rd_seen)
        begin
            @(posedge clk);
            #1;
        end
        // Last response reaches the counters two edges later
        repeat (3)
        begin
            @(posedge clk);
            #1;
        end

        assert (done_seen == 1)
        else report_error($sformatf("done high for %0d cycles, expected 1", done_seen));
        assert (cnt_wr == wr_seen)
        else report_error($sformatf("cnt_wr %0d, writes seen %0d", cnt_wr, wr_seen));
        assert (cnt_rd_rsp == rd_seen)
        else report_error($sformatf("cnt_rd_rsp %0d, reads seen %0d", cnt_rd_rsp, rd_seen));
        if (checker_on)
        begin
            assert ((cnt_checked == meta_seen) && (meta_seen != 0))
            else report_error($sformatf("cnt_checked %0d, checked responses %0d",
                                        cnt_checked, meta_seen));
        end
        else
        begin
            assert (cnt_checked == 0)
            else report_error($sformatf("cnt_checked %0d with checker off", cnt_checked));
        end
        if (conflicts_on)
        begin
            assert (tag_seen != 0)
            else report_error("no checked read returned a written line");
        end
        assert (!corrupt_on || corrupted)
        else report_error("no checked response was corrupted");
        assert (error == expect_error)
        else report_error($sformatf("error %b, expected %b", error, expect_error));
        corrupt_arm = 1'b0;
    endtask

    // ====================
    // Watchdog
    // ====================
    initial
    begin
        #((RUN_TOTAL + RAM_CLEAR + MARGIN) * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $fatal(1, "timeout");
    end

    // ====================
    // Test sequence
    // ====================
    initial
    begin
        reset = 1'b1;
        start = 1'b0;
        run_cycles = '0;
        enable_reads = 1'b0;
        enable_writes = 1'b0;
        enable_checker = 1'b0;
        allow_conflicts = 1'b0;
        stall_mode = 1'b0;
        corrupt_arm = 1'b0;
        corrupt_byte = 3'd0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        // Idle outputs while the tag RAM clears
        repeat (RAM_CLEAR + 10)
        begin
            @(posedge clk);
            #1;
            assert (!busy && !done && !rd_valid && !wr_valid && !error)
            else report_error("status or request outputs high before start");
            assert ((cnt_rd_rsp == 0) && (cnt_wr == 0) && (cnt_checked == 0))
            else report_error("counters nonzero before start");
        end

        // Honest memory, then honest memory under stalls
        run_test(RUN_LEN, 1'b1, 1'b0, 1'b0, 1'b0, 3'd0, 1'b0);
        run_test(STALL_RUN_LEN, 1'b1, 1'b1, 1'b0, 1'b0, 3'd0, 1'b0);
        // Byte 3 is in the tag, byte 1 is not
        run_test(RUN_LEN, 1'b1, 1'b0, 1'b0, 1'b1, 3'd3, 1'b1);
        run_test(RUN_LEN, 1'b1, 1'b0, 1'b0, 1'b1, 3'd1, 1'b0);
        // Checker off hides the corruption
        run_test(RUN_LEN, 1'b0, 1'b0, 1'b0, 1'b1, 3'd3, 1'b0);
        // Reads share lines with the writes of all earlier runs
        run_test(RUN_LEN, 1'b1, 1'b0, 1'b1, 1'b0, 3'd0, 1'b0);

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: rtl/expect_store.sv
// ====================
// Tag RAM and expected-tag FIFO, cleared for 2**CHK_W cycles after reset
// FIFO has no overflow guard, the producer stops at the almost-full level
// ====================
`timescale 1ns/1ps

module expect_store
(
    input  logic clk,
    input  logic reset,

    // Checked reads and writes from the producer
    input  logic chk_rd,
    input  logic [mem_test_pkg::CHK_W-1:0] chk_rd_idx,
    input  logic chk_wr,
    input  logic [mem_test_pkg::CHK_W-1:0] chk_wr_idx,
    input  logic [mem_test_pkg::TAG_W-1:0] chk_wr_tag,

    // Consumer side
    input  logic exp_pop,

    output logic ram_ready,
    output logic exp_full,
    output logic exp_valid,
    output logic [mem_test_pkg::TAG_W-1:0] exp_tag
);

    logic [mem_test_pkg::TAG_W-1:0] tag_ram [2**mem_test_pkg::CHK_W];
    logic [mem_test_pkg::CHK_W-1:0] clr_idx;
    logic [mem_test_pkg::TAG_W-1:0] rd_tag;
    logic rd_q;

    logic [mem_test_pkg::TAG_W-1:0] fifo_mem [mem_test_pkg::FIFO_DEPTH];
    logic [mem_test_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [mem_test_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic [mem_test_pkg::FIFO_PTR_W:0] fifo_cnt;
    logic push;
    logic pop;

    // ====================
    // Tag RAM
    // ====================

    // Sweep every index once, then hold ready
    always_ff @(posedge clk)
    begin
        if (!ram_ready)
        begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == '1)
            begin
                ram_ready <= 1'b1;
            end
        end

        if (reset)
        begin
            clr_idx <= '0;
            ram_ready <= 1'b0;
        end
    end

    // Clear sweep owns the write port until ready
    // Read of a location written in the same cycle returns the old tag
    always_ff @(posedge clk)
    begin
        if (!ram_ready)
        begin
            tag_ram[clr_idx] <= '0;
        end
        else if (chk_wr)
        begin
            tag_ram[chk_wr_idx] <= chk_wr_tag;
        end

        rd_tag <= tag_ram[chk_rd_idx];
    end

    // Marks rd_tag as a pending FIFO entry
    always_ff @(posedge clk)
    begin
        rd_q <= chk_rd;
        if (reset)
        begin
            rd_q <= 1'b0;
        end
    end

    // ====================
    // Expected-tag FIFO
    // ====================
    assign push = rd_q;
    assign pop = exp_pop && exp_valid;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            fifo_mem[wr_ptr] <= rd_tag;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (pop)
        begin
            rd_ptr <= rd_ptr + 1'b1;
        end

        case ({push, pop})
            2'b10: fifo_cnt <= fifo_cnt + 1'b1;
            2'b01: fifo_cnt <= fifo_cnt - 1'b1;
            default: fifo_cnt <= fifo_cnt;
        endcase

        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_cnt <= '0;
        end
    end

    assign exp_valid = (fifo_cnt != '0);
    assign exp_tag = fifo_mem[rd_ptr];

    // Leaves room for the two-cycle RAM pipeline plus the next issue
    assign exp_full = (mem_test_pkg::FIFO_DEPTH - int'(fifo_cnt)) < mem_test_pkg::FIFO_THRESHOLD;

endmodule

// File: rtl/mem_test_pkg.sv
// ====================
// Shared widths, seeds and types of the memory traffic tester
// Line addresses are ADDR_W bits and only a mapped subset is checked
// ====================
package mem_test_pkg;

    // ====================
    // Widths
    // ====================

    // Line address width
    localparam int ADDR_W = 12;
    // Tag RAM index width
    localparam int CHK_W = 8;
    // Low address bits kept in the index
    localparam int CHK_LOW_W = 5;
    // One line of data
    localparam int DATA_W = 64;
    // Compared part of a line
    localparam int TAG_W = 32;
    // Cycle counter and statistics counters
    localparam int COUNT_W = 24;

    // Expected-tag FIFO
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    // Almost full when fewer entries than this are free
    localparam int FIFO_THRESHOLD = 6;

    // ====================
    // LFSR seeds, all nonzero
    // ====================
    localparam logic [31:0] RD_SEED = 32'h0000_2721;
    localparam logic [31:0] WR_SEED = 32'h0000_8520;
    localparam logic [31:0] DATA_SEED = 32'h5a5a_0001;

    // Run control of the producer
    typedef enum logic [1:0]
    {
        IDLE,
        RUN,
        DONE
    } run_state_t;

    // One random word, read either raw or as address fields
    // Middle bits all zero means the line has a tag RAM entry
    typedef union packed
    {
        logic [31:0] raw;
        struct packed
        {
            logic [31-ADDR_W:0] unused;
            logic [CHK_W-CHK_LOW_W-1:0] checked_high;
            logic [ADDR_W-CHK_W-1:0] unchecked_middle;
            logic [CHK_LOW_W-1:0] checked_low;
        } mapped;
    } rand_addr_t;

    // Tag is bytes 7, 5, 3 and 0 of a line, high byte first
    function automatic logic [TAG_W-1:0] line_to_tag(input logic [DATA_W-1:0] line);
        return {line[8*7 +: 8], line[8*5 +: 8], line[8*3 +: 8], line[8*0 +: 8]};
    endfunction

endpackage

// File: rtl/mem_test_top.sv
// ====================
// Memory traffic tester, memory must answer every read once and in order
// ====================
`timescale 1ns/1ps

module mem_test_top
(
    input  logic clk,
    input  logic reset,

    // Host control
    input  logic start,
    input  logic [mem_test_pkg::COUNT_W-1:0] run_cycles,
    input  logic enable_reads,
    input  logic enable_writes,
    input  logic enable_checker,
    input  logic allow_conflicts,

    // Memory side
    input  logic mem_stall,
    input  logic rsp_valid,
    input  logic [mem_test_pkg::DATA_W-1:0] rsp_data,
    input  logic rsp_meta,

    output logic rd_valid,
    output logic [mem_test_pkg::ADDR_W-1:0] rd_addr,
    output logic rd_meta,
    output logic wr_valid,
    output logic [mem_test_pkg::ADDR_W-1:0] wr_addr,
    output logic [mem_test_pkg::DATA_W-1:0] wr_data,

    // Status
    output logic busy,
    output logic done,
    output logic error,
    output logic [mem_test_pkg::COUNT_W-1:0] cnt_rd_rsp,
    output logic [mem_test_pkg::COUNT_W-1:0] cnt_wr,
    output logic [mem_test_pkg::COUNT_W-1:0] cnt_checked
);

    // Producer to buffer
    logic chk_rd;
    logic [mem_test_pkg::CHK_W-1:0] chk_rd_idx;
    logic chk_wr;
    logic [mem_test_pkg::CHK_W-1:0] chk_wr_idx;
    logic [mem_test_pkg::TAG_W-1:0] chk_wr_tag;
    logic ram_ready;
    logic exp_full;

    // Buffer to consumer
    logic exp_valid;
    logic [mem_test_pkg::TAG_W-1:0] exp_tag;
    logic exp_pop;

    traffic_gen i_traffic_gen
    (
        .clk,
        .reset,
        .start,
        .run_cycles,
        .enable_reads,
        .enable_writes,
        .allow_conflicts,
        .mem_stall,
        .ram_ready,
        .exp_full,
        .busy,
        .done,
        .rd_valid,
        .rd_addr,
        .rd_meta,
        .wr_valid,
        .wr_addr,
        .wr_data,
        .chk_rd,
        .chk_rd_idx,
        .chk_wr,
        .chk_wr_idx,
        .chk_wr_tag
    );

    expect_store i_expect_store
    (
        .clk,
        .reset,
        .chk_rd,
        .chk_rd_idx,
        .chk_wr,
        .chk_wr_idx,
        .chk_wr_tag,
        .exp_pop,
        .ram_ready,
        .exp_full,
        .exp_valid,
        .exp_tag
    );

    resp_checker i_resp_checker
    (
        .clk,
        .reset,
        .start,
        .enable_checker,
        .rsp_valid,
        .rsp_data,
        .rsp_meta,
        .exp_valid,
        .exp_tag,
        .wr_valid,
        .exp_pop,
        .error,
        .cnt_rd_rsp,
        .cnt_wr,
        .cnt_checked
    );

endmodule

// File: rtl/resp_checker.sv
// ====================
// In-order response checker, one stage of registers before the compare
// ====================
`timescale 1ns/1ps

module resp_checker
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic enable_checker,

    // Read responses, in issue order
    input  logic rsp_valid,
    input  logic [mem_test_pkg::DATA_W-1:0] rsp_data,
    input  logic rsp_meta,

    // Head of the expected-tag FIFO
    input  logic exp_valid,
    input  logic [mem_test_pkg::TAG_W-1:0] exp_tag,

    // Issued writes
    input  logic wr_valid,

    output logic exp_pop,
    output logic error,
    output logic [mem_test_pkg::COUNT_W-1:0] cnt_rd_rsp,
    output logic [mem_test_pkg::COUNT_W-1:0] cnt_wr,
    output logic [mem_test_pkg::COUNT_W-1:0] cnt_checked
);

    logic rsp_valid_q;
    logic rsp_meta_q;
    logic [mem_test_pkg::TAG_W-1:0] rsp_tag_q;
    logic chk_en;

    // First stage, keep only the tag bytes
    always_ff @(posedge clk)
    begin
        rsp_valid_q <= rsp_valid;
        if (reset)
        begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        rsp_meta_q <= rsp_meta;
        rsp_tag_q <= mem_test_pkg::line_to_tag(rsp_data);
    end

    // Checked responses consume their entry even with the checker off
    assign exp_pop = rsp_valid_q && rsp_meta_q && exp_valid;

    // ====================
    // Compare and count
    // ====================
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            chk_en <= enable_checker;
        end

        if (rsp_valid_q)
        begin
            cnt_rd_rsp <= cnt_rd_rsp + 1'b1;
        end
        if (wr_valid)
        begin
            cnt_wr <= cnt_wr + 1'b1;
        end

        if (exp_pop && chk_en)
        begin
            cnt_checked <= cnt_checked + 1'b1;
            // Sticky until the next start
            if (rsp_tag_q != exp_tag)
            begin
                error <= 1'b1;
            end
        end

        // New run starts from clean statistics
        if (reset || start)
        begin
            cnt_rd_rsp <= '0;
            cnt_wr <= '0;
            cnt_checked <= '0;
            error <= 1'b0;
        end
        if (reset)
        begin
            chk_en <= 1'b0;
        end
    end

endmodule

// File: rtl/traffic_gen.sv
// ====================
// Random read and write producer, settings are sampled with start
// Requests issue one cycle after the decision edge and never under back-pressure
// ====================
`timescale 1ns/1ps

module traffic_gen
(
    input  logic clk,
    input  logic reset,

    // Run control
    input  logic start,
    input  logic [mem_test_pkg::COUNT_W-1:0] run_cycles,
    input  logic enable_reads,
    input  logic enable_writes,
    input  logic allow_conflicts,

    // Back-pressure
    input  logic mem_stall,
    input  logic ram_ready,
    input  logic exp_full,

    output logic busy,
    output logic done,

    // Memory requests
    output logic rd_valid,
    output logic [mem_test_pkg::ADDR_W-1:0] rd_addr,
    output logic rd_meta,
    output logic wr_valid,
    output logic [mem_test_pkg::ADDR_W-1:0] wr_addr,
    output logic [mem_test_pkg::DATA_W-1:0] wr_data,

    // Tag RAM access
    output logic chk_rd,
    output logic [mem_test_pkg::CHK_W-1:0] chk_rd_idx,
    output logic chk_wr,
    output logic [mem_test_pkg::CHK_W-1:0] chk_wr_idx,
    output logic [mem_test_pkg::TAG_W-1:0] chk_wr_tag
);

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] r);
        return {r[30:0], r[31] ^ r[21] ^ r[1] ^ r[0]};
    endfunction

    mem_test_pkg::run_state_t state;
    logic start_q;
    logic [mem_test_pkg::COUNT_W-1:0] cycles_rem;
    logic en_reads;
    logic en_writes;
    logic en_conflicts;

    logic [31:0] rd_lfsr;
    logic [31:0] wr_lfsr;
    logic [31:0] data_lo;
    logic [31:0] data_hi;
    mem_test_pkg::rand_addr_t rd_rand;
    mem_test_pkg::rand_addr_t wr_rand;
    logic rd_checked;
    logic wr_checked;
    logic can_issue;

    // ====================
    // Run state machine
    // ====================
    always_ff @(posedge clk)
    begin
        start_q <= 1'b0;

        if (state == mem_test_pkg::RUN)
        begin
            cycles_rem <= cycles_rem - 1'b1;
        end

        // Load settings, the run begins one edge later
        if (start && (state != mem_test_pkg::RUN))
        begin
            start_q <= 1'b1;
            cycles_rem <= run_cycles;
            en_reads <= enable_reads;
            en_writes <= enable_writes;
            en_conflicts <= allow_conflicts;
        end

        case (state)
            mem_test_pkg::IDLE:
            begin
                if (start_q)
                begin
                    state <= mem_test_pkg::RUN;
                end
            end
            mem_test_pkg::RUN:
            begin
                // Last busy cycle
                if (cycles_rem <= 1)
                begin
                    state <= mem_test_pkg::DONE;
                end
            end
            default:
            begin
                state <= mem_test_pkg::IDLE;
            end
        endcase

        if (reset)
        begin
            state <= mem_test_pkg::IDLE;
            start_q <= 1'b0;
            cycles_rem <= '0;
            en_reads <= 1'b0;
            en_writes <= 1'b0;
            en_conflicts <= 1'b0;
        end
    end

    assign busy = (state == mem_test_pkg::RUN);
    assign done = (state == mem_test_pkg::DONE);

    // ====================
    // Random sources
    // ====================
    always_ff @(posedge clk)
    begin
        rd_lfsr <= lfsr_next(rd_lfsr);
        wr_lfsr <= lfsr_next(wr_lfsr);
        data_lo <= lfsr_next(data_lo);
        data_hi <= lfsr_next(data_hi);

        if (reset)
        begin
            rd_lfsr <= mem_test_pkg::RD_SEED;
            wr_lfsr <= mem_test_pkg::WR_SEED;
            data_lo <= mem_test_pkg::DATA_SEED;
            // Half-word swap keeps the two data streams apart
            data_hi <= {mem_test_pkg::DATA_SEED[15:0], mem_test_pkg::DATA_SEED[31:16]};
        end
    end

    // Bit 2 splits reads and writes into disjoint lines
    always_comb
    begin
        rd_rand.raw = rd_lfsr;
        wr_rand.raw = wr_lfsr;
        if (!en_conflicts)
        begin
            rd_rand.mapped.checked_low[2] = 1'b0;
            wr_rand.mapped.checked_low[2] = 1'b1;
        end
    end

    assign rd_checked = (rd_rand.mapped.unchecked_middle == '0);
    assign wr_checked = (wr_rand.mapped.unchecked_middle == '0);

    // No decision on the final busy edge, so nothing shows after busy falls
    assign can_issue = busy && (cycles_rem > 1) && !mem_stall && !exp_full && ram_ready;

    // ====================
    // Request registers
    // ====================
    always_ff @(posedge clk)
    begin
        rd_valid <= can_issue && en_reads;
        chk_rd <= can_issue && en_reads && rd_checked;
        wr_valid <= can_issue && en_writes;
        chk_wr <= can_issue && en_writes && wr_checked;

        if (reset)
        begin
            rd_valid <= 1'b0;
            chk_rd <= 1'b0;
            wr_valid <= 1'b0;
            chk_wr <= 1'b0;
        end
    end

    // Payload follows the valids
    always_ff @(posedge clk)
    begin
        rd_addr <= rd_rand.raw[mem_test_pkg::ADDR_W-1:0];
        rd_meta <= rd_checked;
        chk_rd_idx <= {rd_rand.mapped.checked_high, rd_rand.mapped.checked_low};

        wr_addr <= wr_rand.raw[mem_test_pkg::ADDR_W-1:0];
        wr_data <= {data_hi, data_lo};
        chk_wr_idx <= {wr_rand.mapped.checked_high, wr_rand.mapped.checked_low};
        chk_wr_tag <= mem_test_pkg::line_to_tag({data_hi, data_lo});
    end

endmodule

// File: sim.f
rtl/mem_test_pkg.sv
rtl/traffic_gen.sv
rtl/expect_store.sv
rtl/resp_checker.sv
rtl/mem_test_top.sv
bench/mem_model.sv
bench/mem_test_tb.sv
